// File: compile.f
+incdir+include
design/pkt_link_pkg.sv
design/avalon_st_if.sv
design/packet_sender.sv
design/packet_receiver.sv
design/packet_link.sv
testbench/tb_packet_link.sv

// File: design/avalon_st_if.sv
`default_nettype none
`timescale 1ns/1ps

`include "pkt_link_defs.svh"

interface avalon_st_if;
  import pkt_link_pkg::*;

  beat_t                   data;
  logic [`EMPTY_WIDTH-1:0] empty;
  logic                    startofpacket;
  logic                    endofpacket;
  logic                    valid;
  logic                    ready;

  // A beat moves on a rising edge with valid and ready both high
  modport source (
    output data, empty, startofpacket, endofpacket, valid,
    input  ready
  );

  modport sink (
    input  data, empty, startofpacket, endofpacket, valid,
    output ready
  );

endinterface : avalon_st_if

`default_nettype wire

// File: design/packet_link.sv
`default_nettype none
`timescale 1ns/1ps

// Sender and receiver back to back over one streaming link
module packet_link (
  input  wire                   clk,
  input  wire                   reset_n,

  // Send side
  input  wire                   write_packet,
  input  pkt_link_pkg::packet_t packet_data,
  output logic                  sending,

  // Receive side
  output logic                  packet_valid,
  output pkt_link_pkg::packet_t packet_out,
  input  wire                   packet_ready
);

  avalon_st_if link_if ();

  packet_sender u_sender (
    .clk          (clk),
    .reset_n      (reset_n),
    .write_packet (write_packet),
    .packet_data  (packet_data),
    .sending      (sending),
    .link         (link_if.source)
  );

  packet_receiver u_receiver (
    .clk          (clk),
    .reset_n      (reset_n),
    .link         (link_if.sink),
    .packet_valid (packet_valid),
    .packet_out   (packet_out),
    .packet_ready (packet_ready)
  );

endmodule : packet_link

`default_nettype wire

// File: design/packet_receiver.sv
`default_nettype none
`timescale 1ns/1ps

module packet_receiver (
  input  wire                   clk,
  input  wire                   reset_n,
  avalon_st_if.sink             link,
  output logic                  packet_valid,
  output pkt_link_pkg::packet_t packet_out,
  input  wire                   packet_ready
);
  import pkt_link_pkg::*;

  beat_idx_t beat_cnt;
  beat_idx_t beat_idx;
  packet_t   asm_q;
  packet_t   asm_next;
  logic      beat_fire;

  // The link stalls for as long as a finished packet is held
  assign link.ready = !packet_valid;
  assign beat_fire  = link.valid && link.ready;

  // Start of packet always lands in beat 0, whatever the counter says
  assign beat_idx = link.startofpacket ? '0 : beat_cnt;

  always_comb begin
    asm_next = asm_q;
    case (beat_idx)
      3'd0: begin
        asm_next.dest_addr.hw_addr = link.data;
      end
      3'd1: begin
        asm_next.dest_addr.sw_addr = link.data[31:16];
        asm_next.dest_addr.port    = link.data[15:9];
        asm_next.dest_addr.flag    = link.data[8];
      end
      3'd2: begin
        asm_next.src_addr.hw_addr = link.data;
      end
      3'd3: begin
        asm_next.src_addr.sw_addr = link.data[31:16];
        asm_next.src_addr.port    = link.data[15:9];
        asm_next.src_addr.flag    = link.data[8];
      end
      3'd4: begin
        asm_next.lamport = link.data;
      end
      3'd5: begin
        asm_next.data[31:0] = link.data;
      end
      3'd6: begin
        asm_next.data[63:32] = link.data;
      end
      default: begin
        asm_next.data[95:64] = link.data;
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      beat_cnt <= '0;
    end else if (beat_fire) begin
      if (link.endofpacket) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_idx + 3'd1;
      end
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      packet_valid <= 1'b0;
    end else if (beat_fire && link.endofpacket) begin
      packet_valid <= 1'b1;
    end else if (packet_valid && packet_ready) begin
      packet_valid <= 1'b0;
    end
  end

  // Assembly and output registers carry payload only
  always_ff @(posedge clk) begin
    if (beat_fire) begin
      asm_q <= asm_next;
      if (link.endofpacket) begin
        packet_out <= asm_next;
      end
    end
  end

endmodule : packet_receiver

`default_nettype wire

// File: design/packet_sender.sv
`default_nettype none
`timescale 1ns/1ps

`include "pkt_link_defs.svh"

module packet_sender (
  input  wire                  clk,
  input  wire                  reset_n,
  input  wire                  write_packet,
  input  pkt_link_pkg::packet_t packet_data,
  output logic                 sending,
  avalon_st_if.source          link
);
  import pkt_link_pkg::*;

  typedef enum logic [3:0] {
    IDLE,
    DEST_HW,
    DEST_SW,
    SRC_HW,
    SRC_SW,
    LAMPORT,
    DATA0,
    DATA1,
    DATA2
  } send_state_t;

  send_state_t state;
  send_state_t state_next;
  packet_t     pkt_q;

  // Payload stage, one beat ahead of the link
  beat_t pay_data;
  logic  pay_sop;
  logic  pay_eop;
  logic  pay_valid;

  beat_t beat_word;
  logic  beat_sop;
  logic  beat_eop;
  logic  in_ready;
  logic  load;

  // Second address word: software address, port and flag above the pad byte
  function automatic beat_t addr_low_word(node_addr_t a);
    return {a.sw_addr, a.port, a.flag, `PAD_BYTE};
  endfunction

  assign sending  = (state != IDLE);
  // Output stage can take a beat when it is empty or being drained
  assign in_ready = link.ready || !link.valid;
  assign load     = (state != IDLE) && in_ready;

  assign link.empty = '0;

  always_comb begin
    beat_word  = '0;
    beat_sop   = 1'b0;
    beat_eop   = 1'b0;
    state_next = state;
    case (state)
      DEST_HW: begin
        beat_word  = pkt_q.dest_addr.hw_addr;
        beat_sop   = 1'b1;
        state_next = DEST_SW;
      end
      DEST_SW: begin
        beat_word  = addr_low_word(pkt_q.dest_addr);
        state_next = SRC_HW;
      end
      SRC_HW: begin
        beat_word  = pkt_q.src_addr.hw_addr;
        state_next = SRC_SW;
      end
      SRC_SW: begin
        beat_word  = addr_low_word(pkt_q.src_addr);
        state_next = LAMPORT;
      end
      LAMPORT: begin
        beat_word  = pkt_q.lamport;
        state_next = DATA0;
      end
      DATA0: begin
        beat_word  = pkt_q.data[31:0];
        state_next = DATA1;
      end
      DATA1: begin
        beat_word  = pkt_q.data[63:32];
        state_next = DATA2;
      end
      DATA2: begin
        beat_word  = pkt_q.data[95:64];
        beat_eop   = 1'b1;
        state_next = IDLE;
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= IDLE;
      pay_valid <= 1'b0;
    end else begin
      // A strobe is only taken while idle, otherwise it is dropped
      if (state == IDLE && write_packet) begin
        state <= DEST_HW;
      end else if (load) begin
        state <= state_next;
      end

      if (load) begin
        pay_valid <= 1'b1;
      end else if (pay_valid && in_ready) begin
        pay_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && write_packet) begin
      pkt_q <= packet_data;
    end
    if (load) begin
      pay_data <= beat_word;
      pay_sop  <= beat_sop;
      pay_eop  <= beat_eop;
    end
    if (pay_valid && in_ready) begin
      link.data <= pay_data;
    end
  end

  // Output stage holds everything while the sink stalls
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      link.valid         <= 1'b0;
      link.startofpacket <= 1'b0;
      link.endofpacket   <= 1'b0;
    end else if (pay_valid && in_ready) begin
      link.valid         <= 1'b1;
      link.startofpacket <= pay_sop;
      link.endofpacket   <= pay_eop;
    end else if (link.ready) begin
      link.valid         <= 1'b0;
      link.startofpacket <= 1'b0;
      link.endofpacket   <= 1'b0;
    end
  end

endmodule : packet_sender

`default_nettype wire

// File: design/pkt_link_pkg.sv
`default_nettype none

`include "pkt_link_defs.svh"

package pkt_link_pkg;

  typedef logic [31:0] hw_addr_t;
  typedef logic [15:0] sw_addr_t;
  typedef logic [6:0]  port_t;

  // Full node address, 56 bits
  typedef struct packed {
    hw_addr_t hw_addr;
    sw_addr_t sw_addr;
    port_t    port;
    logic     flag;
  } node_addr_t;

  typedef logic [31:0] lamport_t;
  typedef logic [95:0] payload_t;

  // Field order matches the beat order on the link
  typedef struct packed {
    node_addr_t dest_addr;
    node_addr_t src_addr;
    lamport_t   lamport;
    payload_t   data;
  } packet_t;

  typedef logic [`BEAT_WIDTH-1:0] beat_t;

  // Position of a beat within its packet
  typedef logic [$clog2(`PKT_BEATS)-1:0] beat_idx_t;

endpackage : pkt_link_pkg

`default_nettype wire

// File: include/pkt_link_defs.svh
`ifndef PKT_LINK_DEFS_SVH
`define PKT_LINK_DEFS_SVH

// Beats in one packet on the streaming link
`define PKT_BEATS 8

// Width of one link word
`define BEAT_WIDTH 32

// Every beat is full, so the empty field only exists for the Avalon framing
`define EMPTY_WIDTH 2

// Filler below the software address, port and flag in address beats
`define PAD_BYTE 8'h00

`endif

// File: run_sim.sh
#!/bin/sh
# Builds the packet link testbench with Verilator and runs it

set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_packet_link -f compile.f

./obj_dir/Vtb_packet_link > "$LOG" 2>&1
cat "$LOG"

if grep -q "All checks passed" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi

// File: testbench/tb_packet_link.sv
`default_nettype none
`timescale 1ns/1ps

module tb_packet_link;
  import pkt_link_pkg::*;

  localparam int CLK_PERIOD      = 40;
  localparam int TOTAL_PKTS      = 55;
  localparam int WATCHDOG_CYCLES = TOTAL_PKTS * 40 + 400;

  logic    clk;
  logic    reset_n;
  logic    write_packet;
  packet_t packet_data;
  logic    sending;
  logic    packet_valid;
  packet_t packet_out;
  logic    packet_ready;

  // Internal link, watched for back-pressure behavior
  logic  link_valid;
  logic  link_ready;
  beat_t link_data;
  logic  link_sop;
  logic  link_eop;

  packet_t     ref_q[$];
  packet_t     exp_pkt;
  string       cur_test = "reset_state";
  int          pass_count = 0;
  int          fail_count = 0;
  int          sent_count = 0;
  int          recv_count = 0;
  logic [31:0] rng_state;
  logic [31:0] stall_state;
  logic        traffic_done;

  packet_link u_dut (
    .clk          (clk),
    .reset_n      (reset_n),
    .write_packet (write_packet),
    .packet_data  (packet_data),
    .sending      (sending),
    .packet_valid (packet_valid),
    .packet_out   (packet_out),
    .packet_ready (packet_ready)
  );

  assign link_valid = u_dut.link_if.valid;
  assign link_ready = u_dut.link_if.ready;
  assign link_data  = u_dut.link_if.data;
  assign link_sop   = u_dut.link_if.startofpacket;
  assign link_eop   = u_dut.link_if.endofpacket;

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic packet_t random_packet();
    logic [255:0] bits;
    int           k;
    for (k = 0; k < 8; k++) begin
      bits[k*32 +: 32] = next_rand();
    end
    return packet_t'(bits[$bits(packet_t)-1:0]);
  endfunction

  task automatic check_value(input string test, input string what,
                             input logic [127:0] exp, input logic [127:0] act);
    assert (act === exp) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("FAIL %s: %s expected %0h actual %0h", test, what, exp, act);
    end
  endtask

  task automatic compare_packet(input string test, input packet_t exp, input packet_t act);
    check_value(test, "dest_addr", 128'(exp.dest_addr), 128'(act.dest_addr));
    check_value(test, "src_addr", 128'(exp.src_addr), 128'(act.src_addr));
    check_value(test, "lamport", 128'(exp.lamport), 128'(act.lamport));
    check_value(test, "data", 128'(exp.data), 128'(act.data));
  endtask

  // Waits for an idle sender, then gives a one cycle strobe
  task automatic send_packet(input packet_t p);
    @(negedge clk);
    while (sending) @(negedge clk);
    @(posedge clk);
    write_packet <= 1'b1;
    packet_data  <= p;
    @(posedge clk);
    write_packet <= 1'b0;
  endtask

  task automatic wait_drain(input string test, input int max_cycles);
    int n;
    n = 0;
    while (ref_q.size() != 0 && n < max_cycles) begin
      @(posedge clk);
      n++;
    end
    assert (ref_q.size() == 0) else begin
      fail_count++;
      $display("Error in %s: %0d packets never came out within %0d cycles",
               test, ref_q.size(), max_cycles);
    end
    repeat (4) @(posedge clk);
  endtask

  task automatic report_test(input string name, input int fails_before);
    if (fail_count == fails_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: FAILED with %0d errors", name, fail_count - fails_before);
    end
  endtask

  // Reference queue, sampled on the falling edge where both sides are stable
  always @(negedge clk) begin
    if (reset_n) begin
      if (write_packet && !sending) begin
        ref_q.push_back(packet_data);
        sent_count++;
      end
      if (packet_valid && packet_ready) begin
        recv_count++;
        assert (ref_q.size() != 0) begin
          exp_pkt = ref_q.pop_front();
          compare_packet(cur_test, exp_pkt, packet_out);
        end else begin
          fail_count++;
          $display("Error in %s: a packet came out that was never written", cur_test);
        end
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    !reset_n |-> (!sending && !packet_valid && !link_valid))
  else begin
    fail_count++;
    $display("Error in %s: an output was active during reset", cur_test);
  end

  a_out_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (packet_valid && !packet_ready) |=> (packet_valid && $stable(packet_out)))
  else begin
    fail_count++;
    $display("Error in %s: the offered packet changed while packet_ready was low", cur_test);
  end

  // A stalled beat must stay on the link unchanged
  a_link_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (link_valid && !link_ready) |=>
      (link_valid && $stable(link_data) && $stable(link_sop) && $stable(link_eop)))
  else begin
    fail_count++;
    $display("Error in %s: a stalled link beat changed or vanished", cur_test);
  end

  initial begin
    int      fails_at_start;
    int      sent_at_start;
    int      recv_at_start;
    int      n;
    int      gap;
    packet_t p;

    reset_n      = 1'b0;
    write_packet = 1'b0;
    packet_data  = '0;
    packet_ready = 1'b1;
    traffic_done = 1'b0;
    rng_state    = 32'd99657;
    // The stall stream starts from the inverted seed
    stall_state  = ~32'd99657;

    fails_at_start = fail_count;
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_value(cur_test, "sending after reset", 128'd0, 128'(sending));
      check_value(cur_test, "packet_valid after reset", 128'd0, 128'(packet_valid));
    end
    report_test(cur_test, fails_at_start);

    cur_test = "single_round_trip";
    fails_at_start = fail_count;
    p.dest_addr.hw_addr = 32'h1111_0001;
    p.dest_addr.sw_addr = 16'h2202;
    p.dest_addr.port    = 7'h33;
    p.dest_addr.flag    = 1'b1;
    p.src_addr.hw_addr  = 32'h4444_0005;
    p.src_addr.sw_addr  = 16'h5506;
    p.src_addr.port     = 7'h27;
    p.src_addr.flag     = 1'b0;
    p.lamport           = 32'h0000_1234;
    p.data              = 96'hAAAA_0001_BBBB_0002_CCCC_0003;
    send_packet(p);
    // Count cycles from the accepting edge until packet_valid shows
    @(negedge clk);
    n = 0;
    while (!packet_valid && n < 40) begin
      @(negedge clk);
      n++;
    end
    check_value(cur_test, "latency in cycles", 128'd10, 128'(n));
    wait_drain(cur_test, 40);
    report_test(cur_test, fails_at_start);

    cur_test = "backpressure_order";
    fails_at_start = fail_count;
    recv_at_start  = recv_count;
    @(posedge clk);
    packet_ready <= 1'b0;
    fork
      begin
        for (n = 0; n < 3; n++) begin
          send_packet(random_packet());
        end
      end
      begin
        repeat (60) @(posedge clk);
        @(negedge clk);
        check_value(cur_test, "packet_valid while stalled", 128'd1, 128'(packet_valid));
        @(posedge clk);
        packet_ready <= 1'b1;
      end
    join
    wait_drain(cur_test, 120);
    check_value(cur_test, "packets received", 128'd3, 128'(recv_count - recv_at_start));
    report_test(cur_test, fails_at_start);

    cur_test = "busy_strobe";
    fails_at_start = fail_count;
    recv_at_start  = recv_count;
    p = random_packet();
    send_packet(p);
    @(posedge clk);
    write_packet <= 1'b1;
    packet_data  <= ~p;
    @(negedge clk);
    check_value(cur_test, "sending at second strobe", 128'd1, 128'(sending));
    @(posedge clk);
    write_packet <= 1'b0;
    wait_drain(cur_test, 40);
    repeat (20) @(posedge clk);
    check_value(cur_test, "packets received", 128'd1, 128'(recv_count - recv_at_start));
    check_value(cur_test, "queue entries left", 128'd0, 128'(ref_q.size()));
    report_test(cur_test, fails_at_start);

    cur_test = "random_traffic";
    fails_at_start = fail_count;
    sent_at_start  = sent_count;
    recv_at_start  = recv_count;
    fork
      begin
        for (n = 0; n < 50; n++) begin
          gap = int'(next_rand() % 32'd4);
          repeat (gap) @(posedge clk);
          send_packet(random_packet());
        end
        wait_drain(cur_test, 50 * 40);
        traffic_done = 1'b1;
      end
      begin
        while (!traffic_done) begin
          @(posedge clk);
          stall_state = xorshift32(stall_state);
          packet_ready <= (stall_state[1:0] != 2'b00);
        end
        packet_ready <= 1'b1;
      end
    join
    check_value(cur_test, "packets sent", 128'd50, 128'(sent_count - sent_at_start));
    check_value(cur_test, "packets received", 128'(sent_count - sent_at_start),
                128'(recv_count - recv_at_start));
    check_value(cur_test, "queue entries left", 128'd0, 128'(ref_q.size()));
    report_test(cur_test, fails_at_start);

    $display("Summary: %0d passed, %0d failed, %0d packets sent, %0d received",
             pass_count, fail_count, sent_count, recv_count);
    if (fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule : tb_packet_link

`default_nettype wire
